// File: Bender.yml
package:
  name: riscv_multicycle

export_include_dirs:
  - common

sources:
  - common/rv_pkg.sv
  - controller/mainController.sv
  - controller/aluDecoder.sv
  - datapath/regFile.sv
  - datapath/alu.sv
  - datapath/datapath.sv
  - verilog/riscvMulticycle.sv
  - target: simulation
    files:
      - tb/cpuChecker.sv
      - tb/tbRiscvMulticycle.sv

// File: common/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data and address width, one word
`define RV_XLEN      32

// Architectural register count
`define RV_NREGS     32

`define RV_RESET_PC  32'h0000_0000

// Depth of the unified memory in words
`define RV_MEM_WORDS 256

`endif

// File: common/rv_pkg.sv
package rv_pkg;

    // Standard RV32I major opcodes
    typedef enum logic [6:0] {
        opR      = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opLui    = 7'b0110111
    } opcodeT;

    // Multicycle controller states
    typedef enum logic [3:0] {
        sFetch,
        sDecode,
        sExecImm,
        sExecR,
        sBranch,
        sJalTarget,
        sJalrTarget,
        sMemAddr,
        sAluWb,
        sMemRead,
        sMemWrite,
        sLoadWb,
        sLuiWb,
        sJumpWb
    } ctrlStateT;

    // Coarse ALU request from the controller
    typedef enum logic [1:0] {aluAdd, aluSub, aluFunct} aluOpT;

    typedef enum logic [2:0] {fAdd, fSub, fAnd, fOr, fSlt} aluFuncT;

    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immSrcT;

    typedef enum logic [1:0] {resAluOut, resData, resAluNow, resImm} resultSrcT;

    typedef enum logic [1:0] {aPc, aOldPc, aReg} srcAT;

    typedef enum logic [1:0] {bReg, bImm, bFour} srcBT;

    typedef struct packed {
        logic      pcUpdate;
        logic      branch;
        logic      adrSrc;
        logic      memWrite;
        logic      irWrite;
        logic      regWrite;
        resultSrcT resultSrc;
        srcAT      srcA;
        srcBT      srcB;
        aluOpT     aluOp;
        immSrcT    immSrc;
    } ctrlT;

endpackage

// File: controller/aluDecoder.sv
`timescale 1ns/1ps

module aluDecoder (
    input  rv_pkg::aluOpT   aluOp,
    input  logic [2:0]      funct3,
    input  logic            funct7b5,
    input  logic            opb5,
    output rv_pkg::aluFuncT aluFunc
);
    import rv_pkg::*;

    logic isSub;

    // funct7 bit 5 means sub only for register-register forms
    assign isSub = opb5 & funct7b5;

    always_comb begin
        case (aluOp)
            aluAdd: aluFunc = fAdd;
            aluSub: aluFunc = fSub;
            aluFunct: begin
                case (funct3)
                    3'b000:  aluFunc = isSub ? fSub : fAdd;
                    3'b010:  aluFunc = fSlt;
                    3'b110:  aluFunc = fOr;
                    3'b111:  aluFunc = fAnd;
                    default: aluFunc = fAdd;
                endcase
            end
            default: aluFunc = fAdd;
        endcase
    end

endmodule

// File: controller/mainController.sv
`timescale 1ns/1ps

module mainController (
    input  logic           clk,
    input  logic           rst,
    input  rv_pkg::opcodeT opcode,
    input  logic [2:0]     funct3,
    input  logic           taken,
    output rv_pkg::ctrlT   ctrl
);
    import rv_pkg::*;

    ctrlStateT state;
    ctrlStateT nextState;
    logic      wordAccess;

    // Only full-word loads and stores are implemented
    assign wordAccess = (funct3 == 3'b010);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= sFetch;
        end else begin
            state <= nextState;
        end
    end

    // ######################################
    // Next state
    // ######################################
    always_comb begin
        nextState = sFetch;
        case (state)
            sFetch: nextState = sDecode;
            sDecode: begin
                case (opcode)
                    opR:      nextState = sExecR;
                    opImm:    nextState = sExecImm;
                    opLoad,
                    opStore:  nextState = wordAccess ? sMemAddr : sFetch;
                    opBranch: nextState = sBranch;
                    opJal:    nextState = sJalTarget;
                    opJalr:   nextState = sJalrTarget;
                    opLui:    nextState = sLuiWb;
                    default:  nextState = sFetch;
                endcase
            end
            sExecR,
            sExecImm:    nextState = sAluWb;
            sMemAddr:    nextState = (opcode == opStore) ? sMemWrite : sMemRead;
            sMemRead:    nextState = sLoadWb;
            sJalTarget,
            sJalrTarget: nextState = sJumpWb;
            default:     nextState = sFetch;
        endcase
    end

    // ######################################
    // State decode
    // ######################################
    always_comb begin
        ctrl = '0;
        case (state)
            sFetch: begin
                // PC + 4 goes straight back into PC
                ctrl.irWrite   = 1'b1;
                ctrl.pcUpdate  = 1'b1;
                ctrl.srcA      = aPc;
                ctrl.srcB      = bFour;
                ctrl.resultSrc = resAluNow;
            end
            sDecode: begin
                // Branch target into ALU-out ahead of time
                ctrl.srcA   = aOldPc;
                ctrl.srcB   = bImm;
                ctrl.immSrc = immB;
            end
            sExecR: begin
                ctrl.srcA  = aReg;
                ctrl.srcB  = bReg;
                ctrl.aluOp = aluFunct;
            end
            sExecImm: begin
                ctrl.srcA   = aReg;
                ctrl.srcB   = bImm;
                ctrl.immSrc = immI;
                ctrl.aluOp  = aluFunct;
            end
            sMemAddr: begin
                ctrl.srcA   = aReg;
                ctrl.srcB   = bImm;
                ctrl.immSrc = (opcode == opStore) ? immS : immI;
            end
            sMemRead: begin
                ctrl.adrSrc    = 1'b1;
                ctrl.resultSrc = resAluOut;
            end
            sMemWrite: begin
                ctrl.adrSrc    = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.resultSrc = resAluOut;
            end
            sAluWb: begin
                ctrl.resultSrc = resAluOut;
                ctrl.regWrite  = 1'b1;
            end
            sLoadWb: begin
                ctrl.resultSrc = resData;
                ctrl.regWrite  = 1'b1;
            end
            sBranch: begin
                // Compare rs1 against rs2, target already waits in ALU-out
                ctrl.srcA      = aReg;
                ctrl.srcB      = bReg;
                ctrl.aluOp     = aluSub;
                ctrl.branch    = 1'b1;
                ctrl.resultSrc = resAluOut;
                ctrl.pcUpdate  = taken;
            end
            sJalTarget: begin
                ctrl.srcA      = aOldPc;
                ctrl.srcB      = bImm;
                ctrl.immSrc    = immJ;
                ctrl.resultSrc = resAluNow;
                ctrl.pcUpdate  = 1'b1;
            end
            sJalrTarget: begin
                ctrl.srcA      = aReg;
                ctrl.srcB      = bImm;
                ctrl.immSrc    = immI;
                ctrl.resultSrc = resAluNow;
                ctrl.pcUpdate  = 1'b1;
            end
            sJumpWb: begin
                // Link address is the old PC plus four
                ctrl.srcA      = aOldPc;
                ctrl.srcB      = bFour;
                ctrl.resultSrc = resAluNow;
                ctrl.regWrite  = 1'b1;
            end
            sLuiWb: begin
                ctrl.immSrc    = immU;
                ctrl.resultSrc = resImm;
                ctrl.regWrite  = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: datapath/alu.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module alu (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  rv_pkg::aluFuncT     func,
    output logic [`RV_XLEN-1:0] y,
    output logic                zero,
    output logic                neg
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] diff;
    logic                overflow;

    assign diff = a - b;

    // Signed a < b, sign of the difference fixed up on overflow
    assign overflow = (a[`RV_XLEN-1] ^ b[`RV_XLEN-1]) & (diff[`RV_XLEN-1] ^ a[`RV_XLEN-1]);
    assign neg      = diff[`RV_XLEN-1] ^ overflow;

    always_comb begin
        case (func)
            fAdd:    y = a + b;
            fSub:    y = diff;
            fAnd:    y = a & b;
            fOr:     y = a | b;
            fSlt:    y = {{(`RV_XLEN-1){1'b0}}, neg};
            default: y = '0;
        endcase
    end

    assign zero = (y == '0);

endmodule

// File: datapath/datapath.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module datapath (
    input  logic                clk,
    input  logic                rst,
    input  rv_pkg::ctrlT        ctrl,
    input  rv_pkg::aluFuncT     aluFunc,
    input  logic [`RV_XLEN-1:0] memRData,
    output logic [`RV_XLEN-1:0] memAddr,
    output logic [`RV_XLEN-1:0] memWData,
    output rv_pkg::opcodeT      opcode,
    output logic [2:0]          funct3,
    output logic                funct7b5,
    output logic                taken
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] oldPc;
    logic [`RV_XLEN-1:0] instr;
    logic [`RV_XLEN-1:0] data;
    logic [`RV_XLEN-1:0] opA;
    logic [`RV_XLEN-1:0] opB;
    logic [`RV_XLEN-1:0] aluOut;
    logic [`RV_XLEN-1:0] rd1;
    logic [`RV_XLEN-1:0] rd2;
    logic [`RV_XLEN-1:0] immExt;
    logic [`RV_XLEN-1:0] srcAVal;
    logic [`RV_XLEN-1:0] srcBVal;
    logic [`RV_XLEN-1:0] aluResult;
    logic [`RV_XLEN-1:0] result;
    logic                zero;
    logic                neg;
    logic                cond;

    assign opcode   = opcodeT'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    // ######################################
    // Architectural registers
    // ######################################
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
        end else if (ctrl.pcUpdate) begin
            pc <= {result[`RV_XLEN-1:1], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.irWrite) begin
            instr <= memRData;
            oldPc <= pc;
        end
    end

    // Staging registers reload every cycle
    always_ff @(posedge clk) begin
        data   <= memRData;
        opA    <= rd1;
        opB    <= rd2;
        aluOut <= aluResult;
    end

    regFile regs (
        .clk (clk),
        .rst (rst),
        .ra1 (instr[19:15]),
        .ra2 (instr[24:20]),
        .wa  (instr[11:7]),
        .we  (ctrl.regWrite),
        .wd  (result),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    always_comb begin
        case (ctrl.immSrc)
            immI:    immExt = {{20{instr[31]}}, instr[31:20]};
            immS:    immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB:    immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            immU:    immExt = {instr[31:12], 12'b0};
            immJ:    immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: immExt = '0;
        endcase
    end

    // ######################################
    // ALU operands and result
    // ######################################
    always_comb begin
        case (ctrl.srcA)
            aPc:     srcAVal = pc;
            aOldPc:  srcAVal = oldPc;
            aReg:    srcAVal = opA;
            default: srcAVal = '0;
        endcase
        case (ctrl.srcB)
            bReg:    srcBVal = opB;
            bImm:    srcBVal = immExt;
            bFour:   srcBVal = `RV_XLEN'd4;
            default: srcBVal = '0;
        endcase
    end

    alu mainAlu (
        .a    (srcAVal),
        .b    (srcBVal),
        .func (aluFunc),
        .y    (aluResult),
        .zero (zero),
        .neg  (neg)
    );

    always_comb begin
        case (ctrl.resultSrc)
            resAluOut: result = aluOut;
            resData:   result = data;
            resAluNow: result = aluResult;
            resImm:    result = immExt;
            default:   result = aluOut;
        endcase
    end

    // beq, bne, blt
    always_comb begin
        case (funct3)
            3'b000:  cond = zero;
            3'b001:  cond = ~zero;
            3'b100:  cond = neg;
            default: cond = 1'b0;
        endcase
    end

    assign taken    = ctrl.branch & cond;
    assign memAddr  = ctrl.adrSrc ? result : pc;
    assign memWData = opB;

endmodule

// File: datapath/regFile.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module regFile (
    input  logic                clk,
    input  logic                rst,
    input  logic [4:0]          ra1,
    input  logic [4:0]          ra2,
    input  logic [4:0]          wa,
    input  logic                we,
    input  logic [`RV_XLEN-1:0] wd,
    output logic [`RV_XLEN-1:0] rd1,
    output logic [`RV_XLEN-1:0] rd2
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    // x0 is cleared by reset and never written
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

// File: project.f
+incdir+common
common/rv_pkg.sv
controller/mainController.sv
controller/aluDecoder.sv
datapath/regFile.sv
datapath/alu.sv
datapath/datapath.sv
verilog/riscvMulticycle.sv
tb/cpuChecker.sv
tb/tbRiscvMulticycle.sv

// File: tb/cpuChecker.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module cpuChecker (
    input logic                clk,
    input logic                rst,
    input logic                memWrite,
    input logic [`RV_XLEN-1:0] memAddr,
    input rv_pkg::ctrlStateT   state
);
    import rv_pkg::*;

    int assertFails = 0;

    // ######################################
    // Reset
    // ######################################
    resetQuiet: assert property (@(posedge clk) rst |-> !memWrite)
        else begin
            assertFails++;
            $error("memWrite active while reset is asserted");
        end

    firstCycleQuiet: assert property (@(posedge clk) $fell(rst) |-> !memWrite)
        else begin
            assertFails++;
            $error("memWrite active in the first cycle after reset");
        end

    // ######################################
    // FSM and memory port
    // ######################################
    singlePulse: assert property (@(posedge clk) disable iff (rst) memWrite |=> !memWrite)
        else begin
            assertFails++;
            $error("memWrite held for more than one cycle");
        end

    legalState: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(state) && (state <= sJumpWb))
        else begin
            assertFails++;
            $error("Controller state outside the legal encodings");
        end

    // Only full words are stored
    alignedStore: assert property (@(posedge clk) disable iff (rst)
        memWrite |-> (memAddr[1:0] == 2'b00))
        else begin
            assertFails++;
            $error("Store to an address that is not word aligned");
        end

endmodule

// File: tb/tbRiscvMulticycle.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module tbRiscvMulticycle;

    localparam int         idxBits    = $clog2(`RV_MEM_WORDS);
    localparam logic [6:0] opRCode    = 7'b0110011;
    localparam logic [6:0] opImmCode  = 7'b0010011;
    localparam logic [6:0] opLoadCode = 7'b0000011;
    localparam logic [6:0] opStCode   = 7'b0100011;
    localparam logic [6:0] opBrCode   = 7'b1100011;
    localparam logic [6:0] opJalCode  = 7'b1101111;
    localparam logic [6:0] opJalrCode = 7'b1100111;
    localparam logic [6:0] opLuiCode  = 7'b0110111;

    logic                clk;
    logic                rst;
    logic [`RV_XLEN-1:0] memAddr;
    logic [`RV_XLEN-1:0] memWData;
    logic [`RV_XLEN-1:0] memRData;
    logic                memWrite;

    logic [31:0] mem    [`RV_MEM_WORDS];
    logic [31:0] refMem [`RV_MEM_WORDS];
    logic [31:0] expAddr[$];
    logic [31:0] expData[$];
    logic [31:0] haltAddr;
    int          wordPtr     = 0;
    int          storeOff    = 0;
    int          expCycles   = 0;
    int          retired     = 0;
    int          cycle       = 0;
    int          haltCycle   = 0;
    int          storeCount  = 0;
    int          storeErrors = 0;
    int          cycleErrors = 0;
    int          otherErrors = 0;
    bit          done        = 1'b0;
    bit          timedOut    = 1'b0;

    riscvMulticycle dut (
        .clk      (clk),
        .rst      (rst),
        .memAddr  (memAddr),
        .memWData (memWData),
        .memWrite (memWrite),
        .memRData (memRData)
    );

    bind riscvMulticycle cpuChecker protocolChk (
        .clk      (clk),
        .rst      (rst),
        .memWrite (memWrite),
        .memAddr  (memAddr),
        .state    (mainCtrl.state)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Unified memory with combinational read
    assign memRData = mem[memAddr[idxBits+1:2]];

    always @(posedge clk) begin
        if (memWrite) begin
            mem[memAddr[idxBits+1:2]] <= memWData;
        end
    end

    // ######################################
    // Program builder
    // ######################################
    function automatic logic [31:0] fillWord(int idx);
        return 32'h1234_5678 ^ (idx * 32'h9e37_79b9);
    endfunction

    function automatic logic [11:0] rnd12();
        logic [31:0] r;
        r = $urandom();
        return r[11:0];
    endfunction

    function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opRCode};
    endfunction

    function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStCode};
    endfunction

    function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBrCode};
    endfunction

    function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJalCode};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[wordPtr] = word;
        wordPtr++;
    endtask

    // sw rs, storeOff(x10)
    task automatic storeReg(input logic [4:0] rs);
        emit(encS(12'(storeOff), rs, 5'd10));
        storeOff += 4;
    endtask

    task automatic buildProgram();
        logic [31:0] r;
        r = $urandom();
        // Prologue with random operands
        // x10 holds the data pointer
        emit({r[31:12], 5'd1, opLuiCode});
        emit(encI(rnd12(), 5'd1, 3'b000, 5'd1, opImmCode));
        emit(encI(rnd12(), 5'd0, 3'b000, 5'd2, opImmCode));
        emit(encI(rnd12(), 5'd0, 3'b000, 5'd3, opImmCode));
        emit(encI(12'h300, 5'd0, 3'b000, 5'd10, opImmCode));
        // ALU results
        emit(encR(7'h00, 5'd3, 5'd2, 3'b000, 5'd4));
        emit(encR(7'h20, 5'd3, 5'd2, 3'b000, 5'd5));
        emit(encR(7'h00, 5'd3, 5'd2, 3'b111, 5'd6));
        emit(encR(7'h00, 5'd3, 5'd1, 3'b110, 5'd7));
        emit(encR(7'h00, 5'd3, 5'd2, 3'b010, 5'd8));
        emit(encI(rnd12(), 5'd1, 3'b111, 5'd9, opImmCode));
        emit(encI(rnd12(), 5'd2, 3'b110, 5'd11, opImmCode));
        emit(encI(rnd12(), 5'd3, 3'b010, 5'd12, opImmCode));
        for (int i = 1; i <= 12; i++) begin
            storeReg(5'(i));
        end
        // Load round trip, untouched fill word and lui
        emit(encI(12'd0, 5'd10, 3'b010, 5'd13, opLoadCode));
        emit(encI(12'd1, 5'd13, 3'b000, 5'd13, opImmCode));
        storeReg(5'd13);
        emit(encI(12'h0f0, 5'd10, 3'b010, 5'd19, opLoadCode));
        storeReg(5'd19);
        r = $urandom();
        emit({r[31:12], 5'd20, opLuiCode});
        storeReg(5'd20);
        // Each branch guards the store after it
        emit(encB(13'd8, 5'd2, 5'd2, 3'b000));
        storeReg(5'd2);
        emit(encB(13'd8, 5'd2, 5'd2, 3'b001));
        storeReg(5'd3);
        emit(encB(13'd8, 5'd3, 5'd2, 3'b100));
        storeReg(5'd4);
        emit(encB(13'd8, 5'd2, 5'd3, 3'b100));
        storeReg(5'd5);
        // Countdown loop closed by a backward bne of 8 bytes
        emit(encI(12'd3, 5'd0, 3'b000, 5'd14, opImmCode));
        storeReg(5'd14);
        emit(encI(12'hfff, 5'd14, 3'b000, 5'd14, opImmCode));
        emit(encB(13'h1ff8, 5'd0, 5'd14, 3'b001));
        // Call past the halt and return through jalr
        emit(encJ(21'd20, 5'd15));
        storeReg(5'd15);
        storeReg(5'd16);
        storeReg(5'd18);
        haltAddr = 32'(wordPtr * 4);
        emit(encJ(21'd0, 5'd0));
        emit(encI(rnd12(), 5'd0, 3'b000, 5'd16, opImmCode));
        emit(encI(12'd0, 5'd15, 3'b000, 5'd18, opJalrCode));
    endtask

    // ######################################
    // Instruction-set reference
    // ######################################
    function automatic int runReference();
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [31:0] res;
        logic [31:0] addr;
        logic [2:0]  f3;
        logic        wr;
        logic        take;
        int          cycles;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        for (int i = 0; i < `RV_MEM_WORDS; i++) begin
            refMem[i] = mem[i];
        end
        pc = `RV_RESET_PC;
        cycles = 0;
        retired = 0;
        while (pc != haltAddr && retired < 1000) begin
            ins = refMem[pc[idxBits+1:2]];
            f3 = ins[14:12];
            a = x[ins[19:15]];
            b = x[ins[24:20]];
            immI = {{20{ins[31]}}, ins[31:20]};
            immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            nextPc = pc + 4;
            res = '0;
            wr = 1'b0;
            case (ins[6:0])
                opRCode, opImmCode: begin
                    if (ins[6:0] == opImmCode) begin
                        b = immI;
                    end
                    case (f3)
                        3'b000: res = (ins[6:0] == opRCode && ins[30]) ? a - b : a + b;
                        3'b010: res = {31'b0, $signed(a) < $signed(b)};
                        3'b110: res = a | b;
                        3'b111: res = a & b;
                        default: res = '0;
                    endcase
                    wr = 1'b1;
                    cycles += 4;
                end
                opLoadCode: begin
                    addr = a + immI;
                    res = refMem[addr[idxBits+1:2]];
                    wr = 1'b1;
                    cycles += 5;
                end
                opStCode: begin
                    addr = a + immS;
                    refMem[addr[idxBits+1:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                    cycles += 4;
                end
                opBrCode: begin
                    case (f3)
                        3'b000: take = (a == b);
                        3'b001: take = (a != b);
                        3'b100: take = $signed(a) < $signed(b);
                        default: take = 1'b0;
                    endcase
                    if (take) begin
                        nextPc = pc + immB;
                    end
                    cycles += 3;
                end
                opJalCode, opJalrCode: begin
                    res = pc + 4;
                    wr = 1'b1;
                    nextPc = (ins[6:0] == opJalCode) ? pc + immJ : (a + immI) & ~32'd1;
                    cycles += 4;
                end
                opLuiCode: begin
                    res = {ins[31:12], 12'b0};
                    wr = 1'b1;
                    cycles += 3;
                end
                default: cycles += 2;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                x[ins[11:7]] = res;
            end
            pc = nextPc;
            retired++;
        end
        return cycles;
    endfunction

    // ######################################
    // Store comparison and halt detection
    // ######################################
    always @(negedge clk) begin : storeMonitor
        logic [31:0] wantAddr;
        logic [31:0] wantData;
        if (!rst) begin
            if (memWrite) begin
                assert (expAddr.size() > 0)
                    else begin
                        otherErrors++;
                        $display("Unexpected store of %h to address %h", memWData, memAddr);
                    end
                if (expAddr.size() > 0) begin
                    wantAddr = expAddr.pop_front();
                    wantData = expData.pop_front();
                    assert (memAddr == wantAddr)
                        else begin
                            storeErrors++;
                            $display("FAILED store #%0d address: expected %h, actual %h",
                                     storeCount, wantAddr, memAddr);
                        end
                    assert (memWData == wantData)
                        else begin
                            storeErrors++;
                            $display("FAILED store #%0d data: expected %h, actual %h",
                                     storeCount, wantData, memWData);
                        end
                    storeCount++;
                end
            end
            if (!done && dut.mainCtrl.state == rv_pkg::sFetch && memAddr == haltAddr) begin
                haltCycle = cycle;
                done = 1'b1;
            end
            cycle++;
        end
    end

    // Watchdog at four times the predicted run length
    initial begin
        wait (expCycles > 0);
        @(negedge rst);
        repeat (4 * expCycles) @(posedge clk);
        timedOut = 1'b1;
    end

    initial begin
        int checkerErrors;
        int totalErrors;
        void'($urandom(32'h448a_4ea7));
        rst = 1'b1;
        for (int i = 0; i < `RV_MEM_WORDS; i++) begin
            mem[i] = fillWord(i);
        end
        buildProgram();
        expCycles = runReference();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        wait (done || timedOut);
        repeat (2) @(posedge clk);
        if (!done) begin
            otherErrors++;
            $display("Watchdog expired: halt address %h not fetched within %0d cycles",
                     haltAddr, 4 * expCycles);
        end else begin
            assert (haltCycle == expCycles)
                else begin
                    cycleErrors++;
                    $display("FAILED cycle count: expected %0d, actual %0d",
                             expCycles, haltCycle);
                end
        end
        assert (expAddr.size() == 0)
            else begin
                otherErrors++;
                $display("%0d predicted stores never happened", expAddr.size());
            end
        checkerErrors = dut.protocolChk.assertFails;
        totalErrors = storeErrors + cycleErrors + otherErrors + checkerErrors;
        $display("Errors: store %0d, cycle %0d, other %0d, assertion %0d (%0d retired, %0d stores)",
                 storeErrors, cycleErrors, otherErrors, checkerErrors,
                 retired, storeCount);
        if (totalErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/riscvMulticycle.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module riscvMulticycle (
    input  logic                clk,
    input  logic                rst,
    output logic [`RV_XLEN-1:0] memAddr,
    output logic [`RV_XLEN-1:0] memWData,
    output logic                memWrite,
    input  logic [`RV_XLEN-1:0] memRData
);
    import rv_pkg::*;

    ctrlT       ctrl;
    opcodeT     opcode;
    aluFuncT    aluFunc;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       taken;

    mainController mainCtrl (
        .clk    (clk),
        .rst    (rst),
        .opcode (opcode),
        .funct3 (funct3),
        .taken  (taken),
        .ctrl   (ctrl)
    );

    // Opcode bit 5 tells R-type sub from addi
    aluDecoder aluDec (
        .aluOp    (ctrl.aluOp),
        .funct3   (funct3),
        .funct7b5 (funct7b5),
        .opb5     (opcode[5]),
        .aluFunc  (aluFunc)
    );

    datapath dp (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .aluFunc  (aluFunc),
        .memRData (memRData),
        .memAddr  (memAddr),
        .memWData (memWData),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7b5 (funct7b5),
        .taken    (taken)
    );

    assign memWrite = ctrl.memWrite;

endmodule
